// ==== Makefile ====
# Verilator build and run of the square root pipeline testbench

LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/Vsqrt_tb: verilog.f $(shell cat verilog.f)
	verilator --binary --timing --assert --top-module sqrt_tb -f verilog.f

run: obj_dir/Vsqrt_tb
	./obj_dir/Vsqrt_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || (echo "no result found in $(LOG)"; exit 1)

lint:
	verilator --lint-only -Wall --top-module sqrt_pipe_top $(filter design/%,$(shell cat verilog.f))

clean:
	rm -rf obj_dir $(LOG)

// ==== design/sqrt_collect.sv ====
`default_nettype none

module sqrt_collect (
	input  wire                   CLK,
	input  wire                   RESET,
	input  wire                   valid,
	input  sqrt_types_pkg::rem_t  rem,
	input  sqrt_types_pkg::root_t root,
	output sqrt_types_pkg::root_t result,
	output logic                  exact,
	output logic                  done
);

	import sqrt_types_pkg::*;

	// done pulses one cycle behind the last stage
	always_ff @(posedge CLK) begin
		if (RESET) begin
			done <= 1'b0;
		end else begin
			done <= valid;
		end
	end

	// result and exact hold until the next operation lands
	always_ff @(posedge CLK) begin
		if (RESET) begin
			result <= '0;
			exact <= 1'b0;
		end else if (valid) begin
			result <= root;
			// nothing left over means root*root hit the operand exactly
			exact <= (rem == '0);
		end
	end

	// launch spacing must survive the whole pipeline
	a_done_single: assert property (
		@(posedge CLK) disable iff (RESET)
		done |=> !done
	) else $error("sqrt_collect: done high on consecutive cycles");

endmodule

`default_nettype wire

// ==== design/sqrt_config_pkg.sv ====
`default_nettype none

package sqrt_config_pkg;

	// unsigned integer input
	localparam int RADICAND_W = 24;

	// fraction bits carried by the root
	localparam int FRAC_BITS = 4;

	// radicand padded with two zero bits per fraction bit
	localparam int OPERAND_W = RADICAND_W + 2 * FRAC_BITS;

	// one root bit per pair of operand bits
	localparam int ROOT_W = OPERAND_W / 2;

	// remainder never exceeds twice the root, plus guard bit
	localparam int REM_W = ROOT_W + 2;

	// recurrence steps folded into one register stage
	localparam int ITER_PER_STAGE = 2;
	localparam int STAGE_COUNT = ROOT_W / ITER_PER_STAGE;

	// edges after the launch edge, one per stage plus the collect register
	localparam int LATENCY = STAGE_COUNT + 1;

endpackage

`default_nettype wire

// ==== design/sqrt_launch.sv ====
`default_nettype none

module sqrt_launch (
	input  wire                       CLK,
	input  wire                       RESET,
	input  wire                       start,
	input  sqrt_types_pkg::radicand_t radicand,
	output logic                      valid,
	output sqrt_types_pkg::operand_t  operand,
	output sqrt_types_pkg::rem_t      rem,
	output sqrt_types_pkg::root_t     root
);

	import sqrt_config_pkg::*;
	import sqrt_types_pkg::*;

	// start as sampled on the previous edge
	logic prev_start;
	logic start_rise;

	// low at the last edge, high at this one
	assign start_rise = start & ~prev_start;

	always_ff @(posedge CLK) begin
		if (RESET) begin
			prev_start <= 1'b0;
			valid <= 1'b0;
		end else begin
			prev_start <= start;
			valid <= start_rise;
		end
	end

	// payload loads only on a launch
	always_ff @(posedge CLK) begin
		if (start_rise) begin
			// append the fraction pairs below the integer bits
			operand <= operand_t'({radicand, {(2 * FRAC_BITS){1'b0}}});
			// recurrence starts from an empty remainder and root
			rem <= '0;
			root <= '0;
		end
	end

	// a held start cannot relaunch, so launches are at least two cycles apart
	a_launch_single: assert property (
		@(posedge CLK) disable iff (RESET)
		valid |=> !valid
	) else $error("sqrt_launch: valid high on consecutive cycles");

endmodule

`default_nettype wire

// ==== design/sqrt_pipe_top.sv ====
`default_nettype none

module sqrt_pipe_top (
	input  wire                       CLK,
	input  wire                       RESET,
	input  wire                       start,
	input  sqrt_types_pkg::radicand_t radicand,
	output sqrt_types_pkg::root_t     result,
	output logic                      exact,
	output logic                      done
);

	import sqrt_config_pkg::*;
	import sqrt_types_pkg::*;

	// slot s feeds stage s, slot STAGE_COUNT feeds collect
	logic     valid_chain   [0:STAGE_COUNT];
	rem_t     rem_chain     [0:STAGE_COUNT];
	root_t    root_chain    [0:STAGE_COUNT];
	// operand is used up by the last stage
	operand_t operand_chain [0:STAGE_COUNT-1];

	sqrt_launch launch_i (
		.CLK      (CLK),
		.RESET    (RESET),
		.start    (start),
		.radicand (radicand),
		.valid    (valid_chain[0]),
		.operand  (operand_chain[0]),
		.rem      (rem_chain[0]),
		.root     (root_chain[0])
	);

	for (genvar s = 0; s < STAGE_COUNT; s++) begin : g_stage
		if (s < STAGE_COUNT - 1) begin : g_mid
			sqrt_stage stage_i (
				.CLK         (CLK),
				.RESET       (RESET),
				.valid_in    (valid_chain[s]),
				.operand_in  (operand_chain[s]),
				.rem_in      (rem_chain[s]),
				.root_in     (root_chain[s]),
				.valid_out   (valid_chain[s+1]),
				.operand_out (operand_chain[s+1]),
				.rem_out     (rem_chain[s+1]),
				.root_out    (root_chain[s+1])
			);
		end else begin : g_last
			sqrt_stage stage_i (
				.CLK         (CLK),
				.RESET       (RESET),
				.valid_in    (valid_chain[s]),
				.operand_in  (operand_chain[s]),
				.rem_in      (rem_chain[s]),
				.root_in     (root_chain[s]),
				.valid_out   (valid_chain[s+1]),
				.operand_out (),
				.rem_out     (rem_chain[s+1]),
				.root_out    (root_chain[s+1])
			);
		end
	end

	sqrt_collect collect_i (
		.CLK    (CLK),
		.RESET  (RESET),
		.valid  (valid_chain[STAGE_COUNT]),
		.rem    (rem_chain[STAGE_COUNT]),
		.root   (root_chain[STAGE_COUNT]),
		.result (result),
		.exact  (exact),
		.done   (done)
	);

endmodule

`default_nettype wire

// ==== design/sqrt_stage.sv ====
`default_nettype none

module sqrt_stage (
	input  wire                      CLK,
	input  wire                      RESET,
	input  wire                      valid_in,
	input  sqrt_types_pkg::operand_t operand_in,
	input  sqrt_types_pkg::rem_t     rem_in,
	input  sqrt_types_pkg::root_t    root_in,
	output logic                     valid_out,
	output sqrt_types_pkg::operand_t operand_out,
	output sqrt_types_pkg::rem_t     rem_out,
	output sqrt_types_pkg::root_t    root_out
);

	import sqrt_config_pkg::*;
	import sqrt_types_pkg::*;

	// remainder with the next operand pair shifted in
	typedef logic [REM_W+1:0] wide_t;

	operand_t op_v;
	rem_t     rem_v;
	root_t    root_v;
	wide_t    shifted;
	wide_t    trial;

	// ITER_PER_STAGE restoring steps chained combinationally
	always_comb begin
		op_v = operand_in;
		rem_v = rem_in;
		root_v = root_in;
		shifted = '0;
		trial = '0;
		for (int i = 0; i < ITER_PER_STAGE; i++) begin
			// bring down the next two radicand bits
			shifted = {rem_v, op_v[OPERAND_W-1 -: 2]};
			op_v = op_v << 2;
			// trial divisor 4*root + 1
			trial = wide_t'({root_v, 2'b01});
			if (shifted >= trial) begin
				// difference always fits, it is at most twice the new root
				rem_v = rem_t'(shifted - trial);
				root_v = {root_v[ROOT_W-2:0], 1'b1};
			end else begin
				// restore, keep shifted remainder
				rem_v = rem_t'(shifted);
				root_v = {root_v[ROOT_W-2:0], 1'b0};
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (RESET) begin
			valid_out <= 1'b0;
		end else begin
			valid_out <= valid_in;
		end
	end

	// data follows every cycle, valid tells the next stage when it counts
	always_ff @(posedge CLK) begin
		operand_out <= op_v;
		rem_out <= rem_v;
		root_out <= root_v;
	end

	// remainder x - q*q stays within 2*q after every step
	a_rem_bound: assert property (
		@(posedge CLK) disable iff (RESET)
		valid_out |-> (rem_out <= rem_t'({root_out, 1'b0}))
	) else $error("sqrt_stage: remainder above twice the root");

endmodule

`default_nettype wire

// ==== design/sqrt_types_pkg.sv ====
`default_nettype none

package sqrt_types_pkg;

	// raw input integer
	typedef logic [sqrt_config_pkg::RADICAND_W-1:0] radicand_t;

	// unconsumed radicand bits, next pair sits in the top two bits
	typedef logic [sqrt_config_pkg::OPERAND_W-1:0] operand_t;

	// partial remainder of the restoring recurrence
	typedef logic [sqrt_config_pkg::REM_W-1:0] rem_t;

	// partial root while in flight, 12.4 fixed point once done
	typedef logic [sqrt_config_pkg::ROOT_W-1:0] root_t;

endpackage

`default_nettype wire

// ==== verif/sqrt_tb.sv ====
`default_nettype none

module sqrt_tb;

	import sqrt_config_pkg::*;
	import sqrt_types_pkg::*;

	// 6 directed + 20 back-to-back + 200 random launches of at most 5 cycles each,
	// plus drain time and the held start, stays well below this
	localparam int MAX_CYCLES = 2000;

	logic      CLK = 1'b0;
	logic      RESET;
	logic      start;
	radicand_t radicand;
	root_t     result;
	logic      exact;
	logic      done;

	// expected results in launch order
	root_t exp_root_q  [$];
	logic  exp_exact_q [$];

	// front of the queue, what the next done must show
	root_t head_root = '0;
	logic  head_exact = 1'b0;

	logic  prev_start_s = 1'b0;
	logic  launch_now;
	logic  any_launch = 1'b0;
	int    pending = 0;
	int    done_count = 0;
	int    cycle = 0;
	int    checks = 0;
	int    error_count = 0;
	int    errors_at_start = 0;
	int    tests_passed = 0;
	int    tests_failed = 0;
	string test_name = "reset";

	sqrt_pipe_top dut_i (
		.CLK      (CLK),
		.RESET    (RESET),
		.start    (start),
		.radicand (radicand),
		.result   (result),
		.exact    (exact),
		.done     (done)
	);

	always #4 CLK = ~CLK;

	// largest root whose square fits under radicand * 2^8
	function automatic root_t fixed_sqrt(input radicand_t value);
		logic [63:0] target;
		logic [63:0] cand;
		root_t r;
		target = 64'(value) << (2 * FRAC_BITS);
		r = '0;
		// set root bits from the top while the square still fits
		for (int b = ROOT_W - 1; b >= 0; b--) begin
			cand = 64'(r | (root_t'(1) << b));
			if (cand * cand <= target) begin
				r = root_t'(cand);
			end
		end
		return r;
	endfunction

	function automatic logic square_fits_exactly(input radicand_t value);
		logic [63:0] r;
		r = 64'(fixed_sqrt(value));
		return (r * r) == (64'(value) << (2 * FRAC_BITS));
	endfunction

	// launch when start is high now and was low at the previous edge
	assign launch_now = start && !prev_start_s;

	// model side, every value read here is the one before the edge
	always @(posedge CLK) begin
		if (RESET) begin
			prev_start_s <= 1'b0;
		end else begin
			prev_start_s <= start;
			if (done) begin
				if (exp_root_q.size() == 0) begin
					$display("%s: done came without any launch waiting for it", test_name);
					error_count = error_count + 1;
				end else begin
					void'(exp_root_q.pop_front());
					void'(exp_exact_q.pop_front());
					checks = checks + 1;
				end
				done_count <= done_count + 1;
			end
			if (launch_now) begin
				exp_root_q.push_back(fixed_sqrt(radicand));
				exp_exact_q.push_back(square_fits_exactly(radicand));
				any_launch <= 1'b1;
			end
			pending <= exp_root_q.size();
			head_root <= (exp_root_q.size() > 0) ? exp_root_q[0] : '0;
			head_exact <= (exp_exact_q.size() > 0) ? exp_exact_q[0] : 1'b0;
		end
	end

	// run limit
	always @(posedge CLK) begin
		if (cycle >= MAX_CYCLES) begin
			$display("timeout: run stopped after %0d cycles in test %s", cycle, test_name);
			$display(">>> FAIL");
			$finish;
		end else begin
			cycle <= cycle + 1;
		end
	end

	// outputs stay cleared until the first launch (first edge still sees X)
	a_idle: assert property (@(posedge CLK)
		(cycle != 0 && !any_launch) |-> (!done && result == '0 && !exact)
	) else begin
		$display("FAILED %s: expected done/result/exact 0/0/0, actual %0d/%0d/%0d",
			test_name, $sampled(done), $sampled(result), $sampled(exact));
		error_count++;
	end

	a_result: assert property (@(posedge CLK) disable iff (RESET)
		done |-> (result == head_root)
	) else begin
		$display("FAILED %s: result expected %0d, actual %0d",
			test_name, $sampled(head_root), $sampled(result));
		error_count++;
	end

	a_exact: assert property (@(posedge CLK) disable iff (RESET)
		done |-> (exact == head_exact)
	) else begin
		$display("FAILED %s: exact expected %0d, actual %0d",
			test_name, $sampled(head_exact), $sampled(exact));
		error_count++;
	end

	// done is raised at launch edge + 9, so it is sampled one edge later
	a_latency: assert property (@(posedge CLK) disable iff (RESET)
		launch_now |-> ##(LATENCY + 1) done
	) else begin
		$display("%s: done missing %0d edges after a launch edge", test_name, LATENCY);
		error_count++;
	end

	a_no_stray: assert property (@(posedge CLK) disable iff (RESET)
		$rose(done) |-> $past(launch_now, LATENCY + 1)
	) else begin
		$display("%s: done rose with no launch %0d edges before", test_name, LATENCY);
		error_count++;
	end

	a_pulse: assert property (@(posedge CLK) disable iff (RESET)
		done |=> !done
	) else begin
		$display("%s: done stayed high for more than one cycle", test_name);
		error_count++;
	end

	// result and exact only move together with done
	a_hold: assert property (@(posedge CLK) disable iff (RESET)
		!done |-> ($stable(result) && $stable(exact))
	) else begin
		$display("%s: result or exact changed without done", test_name);
		error_count++;
	end

	// entered just after an edge, start high for one cycle then low for low_cycles
	task automatic pulse_start(input radicand_t value, input int low_cycles);
		start <= 1'b1;
		radicand <= value;
		@(posedge CLK);
		start <= 1'b0;
		repeat (low_cycles) @(posedge CLK);
	endtask

	task automatic wait_idle();
		@(posedge CLK);
		while (pending != 0) begin
			@(posedge CLK);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors_at_start = error_count;
	endtask

	task automatic end_test();
		if (error_count == errors_at_start) begin
			$display("test %s: passed", test_name);
			tests_passed++;
		end else begin
			$display("test %s: failed with %0d errors", test_name,
				error_count - errors_at_start);
			tests_failed++;
		end
	endtask

	// one value against its hand-computed root
	task automatic check_directed(input radicand_t value, input root_t want, input logic want_exact);
		begin_test($sformatf("directed %0d", value));
		pulse_start(value, 1);
		wait_idle();
		assert (result == want && exact == want_exact) else begin
			$display("FAILED %s: expected %0d exact %0d, actual %0d exact %0d",
				test_name, want, want_exact, result, exact);
			error_count++;
		end
		end_test();
	endtask

	initial begin
		int dones_before;
		void'($urandom(32'hf731_61b3));
		RESET = 1'b1;
		start = 1'b0;
		radicand = '0;

		// reset, then a few idle cycles under the idle check
		begin_test("reset");
		repeat (3) @(posedge CLK);
		RESET <= 1'b0;
		repeat (5) @(posedge CLK);
		end_test();

		check_directed(24'd0, 16'd0, 1'b1);
		check_directed(24'd1, 16'd16, 1'b1);
		check_directed(24'd4, 16'd32, 1'b1);
		check_directed(24'd2, 16'd22, 1'b0);
		check_directed(24'hff_ffff, 16'd65535, 1'b0);
		check_directed(24'd9, 16'd48, 1'b1);

		// single launch, then idle so the hold check sees several cycles
		begin_test("latency");
		pulse_start(24'd12345, 1);
		wait_idle();
		repeat (6) @(posedge CLK);
		end_test();

		// start toggles every cycle, a launch every two cycles
		begin_test("back_to_back");
		repeat (20) pulse_start(radicand_t'($urandom()), 1);
		wait_idle();
		end_test();

		begin_test("held_start");
		dones_before = done_count;
		start <= 1'b1;
		radicand <= 24'd777;
		repeat (10) @(posedge CLK);
		start <= 1'b0;
		wait_idle();
		repeat (4) @(posedge CLK);
		assert (done_count - dones_before == 1) else begin
			$display("FAILED %s: done count expected 1, actual %0d",
				test_name, done_count - dones_before);
			error_count++;
		end
		end_test();

		begin_test("random");
		repeat (200) pulse_start(radicand_t'($urandom()), $urandom_range(4, 1));
		wait_idle();
		end_test();

		repeat (2) @(posedge CLK);
		$display("summary: %0d tests passed, %0d failed, %0d results checked, %0d errors",
			tests_passed, tests_failed, checks, error_count);
		if (error_count == 0 && tests_failed == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/sqrt_config_pkg.sv
design/sqrt_types_pkg.sv
design/sqrt_launch.sv
design/sqrt_stage.sv
design/sqrt_collect.sv
design/sqrt_pipe_top.sv
verif/sqrt_tb.sv
